// ==== logic/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

    // page pool geometry
    localparam int page_aw    = 11;     // 2048 pages
    localparam int page_count = 2048;
    localparam int slot_w     = 3;      // eight words per page

    // packet address is slice index then page number
    localparam int idx_w  = 5;
    localparam int addr_w = 16;

    // header word field positions
    localparam int hdr_dest_lsb  = 0;   // dest port, 4 bits
    localparam int hdr_prior_lsb = 4;   // priority, 3 bits
    localparam int hdr_len_lsb   = 10;  // pages minus one
    localparam int hdr_len_w     = 6;

    // one link table entry per page
    typedef struct packed {
        logic [page_aw-1:0] next_page;  // chain to the following page
        logic               last;       // final page of its packet
        logic [slot_w-1:0]  last_slot;  // highest slot holding data
        logic [7:0]         ecc;        // folded page code
    } page_meta_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_first,   // header page
        wr_later
    } wr_state_e;

    typedef enum logic [1:0] {
        rd_idle,
        rd_fetch,   // wait out the link table read
        rd_stream,
        rd_release  // give the page back
    } rd_state_e;

endpackage

`default_nettype wire

// ==== logic/page_pool_if.sv ====
`default_nettype none

interface page_pool_if;

    logic                             pop;          // take the head page
    logic [sram_pkg::page_aw-1:0]     pop_page;     // page at the head
    logic [sram_pkg::hdr_len_w-1:0]   peek_offset;  // depth to look ahead
    logic [sram_pkg::page_aw-1:0]     peek_page;    // one cycle after offset
    logic                             push;         // return a page
    logic [sram_pkg::page_aw-1:0]     push_page;
    logic                             ready;        // initial fill done

    modport queue (
        input  pop, peek_offset, push, push_page,
        output pop_page, peek_page, ready
    );

    modport writer (
        output pop, peek_offset,
        input  pop_page, peek_page
    );

    modport reader (
        output push, push_page
    );

endinterface

`default_nettype wire

// ==== logic/free_page_queue.sv ====
`default_nettype none

module free_page_queue (
    input  logic        clk,
    input  logic        rst_n,
    page_pool_if.queue  pool
);

    logic [sram_pkg::page_aw-1:0] mem [sram_pkg::page_count];

    logic [sram_pkg::page_aw-1:0] head_q;
    logic [sram_pkg::page_aw-1:0] tail_q;
    logic [sram_pkg::page_aw:0]   fill_q;      // next page to load after reset
    logic                         filling;
    logic                         peeking;
    logic [sram_pkg::page_aw-1:0] peek_ext;
    logic [sram_pkg::page_aw-1:0] head_nxt;
    logic [sram_pkg::page_aw-1:0] rd_addr;
    logic [sram_pkg::page_aw-1:0] rd_q;        // shared read port
    logic [sram_pkg::page_aw-1:0] head_old_q;  // head page at a zero offset peek
    logic                         peek_q;
    logic                         ready_q;

    assign filling  = fill_q != sram_pkg::page_count;
    assign peek_ext = pool.peek_offset;        // zero extended
    assign peeking  = peek_ext != '0;
    assign head_nxt = head_q + {{(sram_pkg::page_aw-1){1'b0}}, pool.pop};

    // peek only on a header, never together with a following pop
    assign rd_addr = peeking ? head_q + peek_ext : head_nxt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            fill_q  <= '0;
            ready_q <= 1'b0;
        end else begin
            head_q  <= head_nxt;
            ready_q <= !filling;
            if (filling) begin
                fill_q <= fill_q + 1'b1;
                tail_q <= tail_q + 1'b1;      // wraps to 0 once full
            end else if (pool.push) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    // fill loads pages in order, later only freed pages arrive
    always_ff @(posedge clk) begin
        if (filling)
            mem[tail_q] <= fill_q[sram_pkg::page_aw-1:0];
        else if (pool.push)
            mem[tail_q] <= pool.push_page;
        rd_q       <= mem[rd_addr];
        head_old_q <= rd_q;
        peek_q     <= peeking;
    end

    assign pool.pop_page  = rd_q;
    assign pool.peek_page = peek_q ? rd_q : head_old_q;   // offset 0 is the head itself
    assign pool.ready     = ready_q;

endmodule

`default_nettype wire

// ==== logic/page_ecc.sv ====
`default_nettype none

module page_ecc (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clear,   // first word of a page
    input  logic        en,
    input  logic [15:0] data,
    output logic [7:0]  code
);

    logic [7:0] folded;
    logic [7:0] base;

    assign folded = data[7:0] ^ data[15:8];   // bit k with bit k+8
    assign base   = clear ? 8'h00 : code;     // restart on a new page

    always_ff @(posedge clk) begin
        if (!rst_n)
            code <= 8'h00;
        else if (en)
            code <= base ^ folded;
    end

endmodule

`default_nettype wire

// ==== logic/sram.sv ====
`default_nettype none

module sram (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [sram_pkg::page_aw-1:0]  wr_page,
    input  logic [sram_pkg::slot_w-1:0]   wr_slot,
    input  logic [15:0]                   din,
    input  logic [sram_pkg::page_aw-1:0]  rd_page,
    input  logic [sram_pkg::slot_w-1:0]   rd_slot,
    output logic [15:0]                   dout
);

    // page number in the upper bits, slot in the lower
    logic [15:0] mem [sram_pkg::page_count * (2 ** sram_pkg::slot_w)];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[{wr_page, wr_slot}] <= din;
        dout <= mem[{rd_page, rd_slot}];   // one cycle read
    end

endmodule

`default_nettype wire

// ==== logic/page_link_table.sv ====
`default_nettype none

module page_link_table (
    input  logic                          clk,
    input  logic                          wr_en,
    input  logic [sram_pkg::page_aw-1:0]  wr_page,
    input  sram_pkg::page_meta_t          wr_meta,
    input  logic                          cat_en,
    input  logic [sram_pkg::page_aw-1:0]  cat_head,
    input  logic [sram_pkg::page_aw-1:0]  cat_tail,
    input  logic [sram_pkg::page_aw-1:0]  rd_page,
    output sram_pkg::page_meta_t          rd_meta
);

    sram_pkg::page_meta_t         mem [sram_pkg::page_count];
    sram_pkg::page_meta_t         cat_meta_q;   // stored entry of cat_head
    logic [sram_pkg::page_aw-1:0] cat_head_q;
    logic [sram_pkg::page_aw-1:0] cat_tail_q;
    logic                         cat_pend_q;   // modified entry due now

    always_ff @(posedge clk) begin
        cat_pend_q <= cat_en;
        cat_head_q <= cat_head;
        cat_tail_q <= cat_tail;
        cat_meta_q <= mem[cat_head];
        rd_meta    <= mem[rd_page];
    end

    // concatenation overrides the writer in the same cycle
    always_ff @(posedge clk) begin
        if (cat_pend_q)
            mem[cat_head_q] <= '{next_page: cat_tail_q,
                                 last:      1'b0,
                                 last_slot: cat_meta_q.last_slot,
                                 ecc:       cat_meta_q.ecc};
        else if (wr_en)
            mem[wr_page] <= wr_meta;
    end

endmodule

`default_nettype wire

// ==== logic/sram_write_ctrl.sv ====
`default_nettype none

module sram_write_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          wr_vld,
    input  logic [15:0]                   wr_data,
    input  logic                          wr_eop,
    page_pool_if.writer                   pool,
    output logic                          ram_wr_en,
    output logic [sram_pkg::page_aw-1:0]  ram_page,
    output logic [sram_pkg::slot_w-1:0]   ram_slot,
    output logic                          meta_wr_en,
    output logic [sram_pkg::page_aw-1:0]  meta_page,
    output sram_pkg::page_meta_t          meta,
    output logic                          join_req,
    output logic [3:0]                    dest,
    output logic [2:0]                    prior,
    output logic [sram_pkg::page_aw-1:0]  head_page,
    output logic [sram_pkg::page_aw-1:0]  tail_page
);

    sram_pkg::wr_state_e          state_q;
    logic [sram_pkg::slot_w-1:0]  slot_q;
    logic [sram_pkg::page_aw-1:0] page_q;        // page being filled
    logic                         hdr;
    logic                         page_start;
    logic                         page_end;
    logic                         last_q;
    logic [sram_pkg::slot_w-1:0]  last_slot_q;
    logic [7:0]                   ecc_code;
    logic                         s1_vld_q;      // header seen last edge
    logic                         s2_vld_q;
    logic [3:0]                   s1_dest_q;
    logic [2:0]                   s1_prior_q;
    logic [sram_pkg::page_aw-1:0] s1_head_q;
    logic [3:0]                   s2_dest_q;
    logic [2:0]                   s2_prior_q;
    logic [sram_pkg::page_aw-1:0] s2_head_q;
    logic [sram_pkg::page_aw-1:0] s2_tail_q;

    assign hdr        = wr_vld && state_q == sram_pkg::wr_idle;
    assign page_start = wr_vld && slot_q == '0;
    assign page_end   = wr_vld && (slot_q == '1 || wr_eop);

    assign pool.pop         = page_start;    // head page taken on slot 0
    assign pool.peek_offset = hdr ? wr_data[sram_pkg::hdr_len_lsb +: sram_pkg::hdr_len_w] : '0;

    assign ram_wr_en = wr_vld;
    assign ram_page  = page_start ? pool.pop_page : page_q;
    assign ram_slot  = slot_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= sram_pkg::wr_idle;
            slot_q  <= '0;
        end else if (wr_vld) begin
            slot_q <= wr_eop ? '0 : slot_q + 1'b1;   // rolls into the next page
            if (wr_eop)
                state_q <= sram_pkg::wr_idle;
            else if (state_q == sram_pkg::wr_idle)
                state_q <= sram_pkg::wr_first;
            else if (slot_q == '1)
                state_q <= sram_pkg::wr_later;
        end
    end

    always_ff @(posedge clk) begin
        if (page_start)
            page_q <= pool.pop_page;
        if (page_end) begin
            meta_page   <= ram_page;
            last_q      <= wr_eop;
            last_slot_q <= slot_q;
        end
    end

    // metadata lands the cycle after the page's last word
    always_ff @(posedge clk) begin
        if (!rst_n)
            meta_wr_en <= 1'b0;
        else
            meta_wr_en <= page_end;
    end

    // next page is whatever the queue hands out next
    assign meta = '{next_page: pool.pop_page,
                    last:      last_q,
                    last_slot: last_slot_q,
                    ecc:       ecc_code};

    page_ecc u_ecc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (slot_q == '0),
        .en    (wr_vld),
        .data  (wr_data),
        .code  (ecc_code)
    );

    // two stage join pipeline, a new header may follow a one word packet
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_vld_q <= 1'b0;
            s2_vld_q <= 1'b0;
            join_req <= 1'b0;
        end else begin
            s1_vld_q <= hdr;
            s2_vld_q <= s1_vld_q;
            join_req <= s2_vld_q;   // high after edge 2
        end
    end

    always_ff @(posedge clk) begin
        if (hdr) begin
            s1_dest_q  <= wr_data[sram_pkg::hdr_dest_lsb +: 4];
            s1_prior_q <= wr_data[sram_pkg::hdr_prior_lsb +: 3];
            s1_head_q  <= pool.pop_page;
        end
        if (s1_vld_q) begin
            s2_dest_q  <= s1_dest_q;
            s2_prior_q <= s1_prior_q;
            s2_head_q  <= s1_head_q;
            s2_tail_q  <= pool.peek_page;   // peek result valid now
        end
        if (s2_vld_q) begin                 // outputs hold until next request
            dest      <= s2_dest_q;
            prior     <= s2_prior_q;
            head_page <= s2_head_q;
            tail_page <= s2_tail_q;
        end
    end

endmodule

`default_nettype wire

// ==== logic/sram_read_ctrl.sv ====
`default_nettype none

module sram_read_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [sram_pkg::page_aw-1:0]  head_page,
    page_pool_if.reader                   pool,
    output logic [sram_pkg::page_aw-1:0]  ram_page,
    output logic [sram_pkg::slot_w-1:0]   ram_slot,
    input  logic [15:0]                   ram_dout,
    output logic [sram_pkg::page_aw-1:0]  meta_page,
    input  sram_pkg::page_meta_t          meta,
    output logic                          vld,
    output logic [15:0]                   data,
    output logic                          eop,
    output logic                          ecc_err,
    output logic                          busy
);

    sram_pkg::rd_state_e          state_q;
    logic [sram_pkg::page_aw-1:0] page_q;       // page being streamed
    logic [sram_pkg::slot_w-1:0]  slot_q;
    logic [sram_pkg::slot_w-1:0]  end_slot;
    logic                         issue;
    logic                         issue_end;
    logic                         first_q;      // page's first word on ram_dout
    logic                         page_end_q;   // page's final word on ram_dout
    logic [7:0]                   ecc_code;
    logic [7:0]                   ecc_calc;

    assign end_slot  = meta.last ? meta.last_slot : '1;   // full page unless last
    assign issue     = state_q == sram_pkg::rd_stream;
    assign issue_end = issue && slot_q == end_slot;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= sram_pkg::rd_idle;
            slot_q     <= '0;
            vld        <= 1'b0;
            first_q    <= 1'b0;
            page_end_q <= 1'b0;
            eop        <= 1'b0;
        end else begin
            case (state_q)
                sram_pkg::rd_idle:
                    if (start)
                        state_q <= sram_pkg::rd_fetch;
                sram_pkg::rd_fetch:
                    state_q <= sram_pkg::rd_stream;   // meta valid next cycle
                sram_pkg::rd_stream:
                    if (slot_q == end_slot)
                        state_q <= sram_pkg::rd_release;
                default:
                    state_q <= meta.last ? sram_pkg::rd_idle : sram_pkg::rd_fetch;
            endcase
            slot_q     <= issue ? slot_q + 1'b1 : '0;
            // ram read is one cycle, flags follow the data
            vld        <= issue;
            first_q    <= issue && slot_q == '0;
            page_end_q <= issue_end;
            eop        <= issue_end && meta.last;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == sram_pkg::rd_idle && start)
            page_q <= head_page;
        else if (state_q == sram_pkg::rd_release)
            page_q <= meta.next_page;   // follow the chain
    end

    assign ram_page  = page_q;
    assign ram_slot  = slot_q;
    assign meta_page = page_q;
    assign data      = ram_dout;
    assign busy      = state_q != sram_pkg::rd_idle;

    // freed page goes back while its last word is out
    assign pool.push      = state_q == sram_pkg::rd_release;
    assign pool.push_page = page_q;

    page_ecc u_ecc (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (first_q),
        .en    (vld),
        .data  (ram_dout),
        .code  (ecc_code)
    );

    // fold in the current word so the check lines up with it
    assign ecc_calc = (first_q ? 8'h00 : ecc_code) ^ ram_dout[7:0] ^ ram_dout[15:8];
    assign ecc_err  = page_end_q && ecc_calc != meta.ecc;

endmodule

`default_nettype wire

// ==== logic/sram_interface.sv ====
`default_nettype none

module sram_interface #(
    parameter logic [sram_pkg::idx_w-1:0] sram_idx = '0   // slice index
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_vld,
    input  logic [15:0]                  wr_data,
    input  logic                         wr_eop,
    output logic                         wr_join_req,
    output logic [3:0]                   wr_dest,
    output logic [2:0]                   wr_prior,
    output logic [sram_pkg::addr_w-1:0]  wr_head,
    output logic [sram_pkg::addr_w-1:0]  wr_tail,
    input  logic                         cat_en,
    input  logic [sram_pkg::addr_w-1:0]  cat_head,
    input  logic [sram_pkg::addr_w-1:0]  cat_tail,
    input  logic                         rd_start,
    input  logic [sram_pkg::addr_w-1:0]  rd_head,
    output logic                         rd_vld,
    output logic [15:0]                  rd_data,
    output logic                         rd_eop,
    output logic                         rd_ecc_err,
    output logic                         rd_busy,
    output logic                         ready
);

    page_pool_if pool ();

    logic                         ram_wr_en;
    logic [sram_pkg::page_aw-1:0] ram_wr_page;
    logic [sram_pkg::slot_w-1:0]  ram_wr_slot;
    logic [sram_pkg::page_aw-1:0] ram_rd_page;
    logic [sram_pkg::slot_w-1:0]  ram_rd_slot;
    logic [15:0]                  ram_dout;
    logic                         meta_wr_en;
    logic [sram_pkg::page_aw-1:0] meta_wr_page;
    sram_pkg::page_meta_t         meta_wr;
    logic [sram_pkg::page_aw-1:0] meta_rd_page;
    sram_pkg::page_meta_t         meta_rd;
    logic [sram_pkg::page_aw-1:0] head_page;
    logic [sram_pkg::page_aw-1:0] tail_page;

    assign wr_head = {sram_idx, head_page};   // slice index on top
    assign wr_tail = {sram_idx, tail_page};
    assign ready   = pool.ready;

    free_page_queue u_queue (.clk(clk), .rst_n(rst_n), .pool(pool));

    sram u_sram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_page (ram_wr_page),
        .wr_slot (ram_wr_slot),
        .din     (wr_data),
        .rd_page (ram_rd_page),
        .rd_slot (ram_rd_slot),
        .dout    (ram_dout)
    );

    // only the page bits of external addresses matter inside the slice
    page_link_table u_links (
        .clk      (clk),
        .wr_en    (meta_wr_en),
        .wr_page  (meta_wr_page),
        .wr_meta  (meta_wr),
        .cat_en   (cat_en),
        .cat_head (cat_head[sram_pkg::page_aw-1:0]),
        .cat_tail (cat_tail[sram_pkg::page_aw-1:0]),
        .rd_page  (meta_rd_page),
        .rd_meta  (meta_rd)
    );

    sram_write_ctrl u_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_vld     (wr_vld),
        .wr_data    (wr_data),
        .wr_eop     (wr_eop),
        .pool       (pool),
        .ram_wr_en  (ram_wr_en),
        .ram_page   (ram_wr_page),
        .ram_slot   (ram_wr_slot),
        .meta_wr_en (meta_wr_en),
        .meta_page  (meta_wr_page),
        .meta       (meta_wr),
        .join_req   (wr_join_req),
        .dest       (wr_dest),
        .prior      (wr_prior),
        .head_page  (head_page),
        .tail_page  (tail_page)
    );

    sram_read_ctrl u_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (rd_start),
        .head_page (rd_head[sram_pkg::page_aw-1:0]),
        .pool      (pool),
        .ram_page  (ram_rd_page),
        .ram_slot  (ram_rd_slot),
        .ram_dout  (ram_dout),
        .meta_page (meta_rd_page),
        .meta      (meta_rd),
        .vld       (rd_vld),
        .data      (rd_data),
        .eop       (rd_eop),
        .ecc_err   (rd_ecc_err),
        .busy      (rd_busy)
    );

endmodule

`default_nettype wire

// ==== tests/tb_sram_interface.sv ====
`default_nettype none

module tb_sram_interface;

    localparam logic [sram_pkg::idx_w-1:0] slice = 5'd3;
    localparam int n_tests        = 6;
    localparam int timeout_cycles = sram_pkg::page_count + 20 + 4000 * n_tests;

    logic                        clk;
    logic                        rst_n;
    logic                        wr_vld;
    logic [15:0]                 wr_data;
    logic                        wr_eop;
    logic                        wr_join_req;
    logic [3:0]                  wr_dest;
    logic [2:0]                  wr_prior;
    logic [sram_pkg::addr_w-1:0] wr_head;
    logic [sram_pkg::addr_w-1:0] wr_tail;
    logic                        cat_en;
    logic [sram_pkg::addr_w-1:0] cat_head;
    logic [sram_pkg::addr_w-1:0] cat_tail;
    logic                        rd_start;
    logic [sram_pkg::addr_w-1:0] rd_head;
    logic                        rd_vld;
    logic [15:0]                 rd_data;
    logic                        rd_eop;
    logic                        rd_ecc_err;
    logic                        rd_busy;
    logic                        ready;

    logic [31:0] lfsr;
    int          err_count;
    int          check_count;
    int          test_errs;        // error count at the start of a test
    int          pops_total;       // pages handed out since reset
    logic        ready_seen;
    logic [sram_pkg::page_aw-1:0] free_q [$];    // model of the free-page FIFO
    logic [sram_pkg::page_aw-1:0] pages_q [$];   // pages of the last write
    logic [sram_pkg::page_aw-1:0] chain_q [$];   // pages a read gives back in order
    logic [15:0]                  pkt_q [$];     // words to write
    logic [15:0]                  exp_q [$];     // words a read must return
    logic [sram_pkg::addr_w-1:0]  exp_head;
    logic [sram_pkg::addr_w-1:0]  exp_tail;

    sram_interface #(.sram_idx(slice)) UUT (
        .clk(clk), .rst_n(rst_n),
        .wr_vld(wr_vld), .wr_data(wr_data), .wr_eop(wr_eop),
        .wr_join_req(wr_join_req), .wr_dest(wr_dest), .wr_prior(wr_prior),
        .wr_head(wr_head), .wr_tail(wr_tail),
        .cat_en(cat_en), .cat_head(cat_head), .cat_tail(cat_tail),
        .rd_start(rd_start), .rd_head(rd_head),
        .rd_vld(rd_vld), .rd_data(rd_data), .rd_eop(rd_eop),
        .rd_ecc_err(rd_ecc_err), .rd_busy(rd_busy), .ready(ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // fill time plus a fixed budget per test
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", timeout_cycles);
        $display("Checks failed");
        $finish;
    end

    // ready must stay up once the fill is done
    always @(negedge clk) begin
        if (ready_seen && ready !== 1'b1) begin
            check_flag("ready", 1'b1, ready);
            ready_seen = 1'b0;   // report once
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);   // one step per bit
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic check_addr(input string name, input logic [sram_pkg::addr_w-1:0] exp,
                              input logic [sram_pkg::addr_w-1:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_field(input string name, input logic [3:0] exp, input logic [3:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        err_count++;
        $display("%s", msg);
    endtask

    task automatic report_test(input string name);
        $display("%-18s finished, %0d errors", name, err_count - test_errs);
        test_errs = err_count;
    endtask

    // header word then random payload words
    task automatic build_packet(input int nwords, input logic [3:0] dest, input logic [2:0] prior);
        logic [15:0] hdr;
        logic [15:0] w;
        int          i;
        rand_bits(3, w);
        hdr = '0;
        hdr[sram_pkg::hdr_dest_lsb +: 4]                   = dest;
        hdr[sram_pkg::hdr_prior_lsb +: 3]                  = prior;
        hdr[9:7]                                           = w[2:0];   // unused bits
        hdr[sram_pkg::hdr_len_lsb +: sram_pkg::hdr_len_w] = (nwords + 7) / 8 - 1;
        pkt_q.delete();
        pkt_q.push_back(hdr);
        for (i = 1; i < nwords; i++) begin
            rand_bits(16, w);
            pkt_q.push_back(w);
        end
    endtask

    // streams pkt_q and checks the join request on the second edge
    task automatic write_packet();
        int          n;
        int          f;
        int          npages;
        int          i;
        logic        done;
        logic [15:0] hdr;
        n      = pkt_q.size();
        hdr    = pkt_q[0];
        npages = int'(hdr[sram_pkg::hdr_len_lsb +: sram_pkg::hdr_len_w]) + 1;
        pages_q.delete();
        for (i = 0; i < npages; i++)
            pages_q.push_back(free_q.pop_front());   // pages leave in FIFO order
        pops_total += npages;
        exp_head = {slice, pages_q[0]};
        exp_tail = {slice, pages_q[npages-1]};
        wr_vld  = 1'b1;
        wr_data = hdr;
        wr_eop  = (n == 1);
        f       = 0;
        done    = 1'b0;
        while (!done) begin
            @(negedge clk);
            f++;                         // state after edge f-1
            if (f == 3) begin
                if (wr_join_req !== 1'b1) begin
                    note_failure($sformatf("missing wr_join_req at %0t, two edges after the header",
                                           $time));
                end else begin
                    check_field("wr_dest", hdr[3:0], wr_dest);
                    check_field("wr_prior", {1'b0, hdr[6:4]}, {1'b0, wr_prior});
                    check_addr("wr_head", exp_head, wr_head);
                    check_addr("wr_tail", exp_tail, wr_tail);
                end
            end else begin
                check_flag("wr_join_req", 1'b0, wr_join_req);   // single pulse only
            end
            if (f < n) begin
                wr_data = pkt_q[f];
                wr_eop  = (f == n - 1);
            end else begin
                wr_vld  = 1'b0;
                wr_eop  = 1'b0;
                wr_data = '0;
            end
            if (f >= 4 && f >= n)
                done = 1'b1;
        end
    endtask

    // expected words and freed pages of the last write
    task automatic stage_readback(input logic append);
        int i;
        if (!append) begin
            exp_q.delete();
            chain_q.delete();
        end
        for (i = 0; i < pkt_q.size(); i++)
            exp_q.push_back(pkt_q[i]);
        for (i = 0; i < pages_q.size(); i++)
            chain_q.push_back(pages_q[i]);
    endtask

    task automatic read_packet(input logic [sram_pkg::addr_w-1:0] head);
        int   idx;
        int   cyc;
        logic done;
        check_flag("rd_busy", 1'b0, rd_busy);
        rd_head  = head;
        rd_start = 1'b1;
        @(negedge clk);
        rd_start = 1'b0;
        idx  = 0;
        cyc  = 0;
        done = 1'b0;
        while (!done && cyc < 1000) begin
            if (rd_vld === 1'b1) begin
                if (idx < exp_q.size())
                    check_word("rd_data", exp_q[idx], rd_data);
                check_flag("rd_eop", idx == exp_q.size() - 1, rd_eop);
                check_flag("rd_ecc_err", 1'b0, rd_ecc_err);
                done = (rd_eop === 1'b1);
                idx++;
            end
            @(negedge clk);
            cyc++;
        end
        if (!done) begin
            note_failure($sformatf("rd_eop never came at %0t, %0d words read", $time, idx));
        end else begin
            if (idx != exp_q.size())
                note_failure($sformatf("read returned %0d words, %0d expected",
                                       idx, exp_q.size()));
            check_flag("rd_busy", 1'b0, rd_busy);   // drops the cycle after eop
        end
        while (chain_q.size() > 0)
            free_q.push_back(chain_q.pop_front());   // reader frees in chain order
    endtask

    task automatic reset_and_fill();
        int cyc;
        repeat (10) @(negedge clk);
        check_flag("wr_join_req", 1'b0, wr_join_req);
        check_flag("rd_vld", 1'b0, rd_vld);
        check_flag("rd_eop", 1'b0, rd_eop);
        check_flag("rd_ecc_err", 1'b0, rd_ecc_err);
        check_flag("rd_busy", 1'b0, rd_busy);
        check_flag("ready", 1'b0, ready);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("ready", 1'b0, ready);   // fill still running
        cyc = 0;
        while (ready !== 1'b1 && cyc < sram_pkg::page_count + 50) begin
            @(negedge clk);
            cyc++;
        end
        if (ready !== 1'b1)
            note_failure("ready did not rise after the page fill");
        else
            ready_seen = 1'b1;
        repeat (20) @(negedge clk);
        report_test("reset_and_fill");
    endtask

    task automatic one_page_packet();
        build_packet(5, 4'ha, 3'd5);
        write_packet();
        check_addr("wr_head", {slice, 11'd0}, wr_head);   // first page out of the queue
        stage_readback(1'b0);
        read_packet(exp_head);
        report_test("one_page_packet");
    endtask

    task automatic three_page_packet();
        build_packet(20, 4'h3, 3'd2);
        write_packet();
        stage_readback(1'b0);
        repeat (2) @(negedge clk);
        read_packet(exp_head);
        report_test("three_page_packet");
    endtask

    task automatic concatenation();
        logic [sram_pkg::addr_w-1:0] head_a;
        logic [sram_pkg::addr_w-1:0] tail_a;
        logic [sram_pkg::addr_w-1:0] head_b;
        build_packet(16, 4'h7, 3'd1);   // full last page so all eight slots stream
        write_packet();
        head_a = exp_head;
        tail_a = exp_tail;
        stage_readback(1'b0);
        repeat (3) @(negedge clk);
        build_packet(11, 4'h2, 3'd6);
        write_packet();
        head_b = exp_head;
        stage_readback(1'b1);
        repeat (3) @(negedge clk);
        cat_en   = 1'b1;                 // writer idle with no page end nearby
        cat_head = tail_a;
        cat_tail = head_b;
        @(negedge clk);
        cat_en = 1'b0;
        repeat (3) @(negedge clk);
        read_packet(head_a);
        report_test("concatenation");
    endtask

    task automatic random_packets();
        logic [15:0] v;
        logic [15:0] d;
        logic [15:0] p;
        int          npages;
        int          k;
        for (k = 0; k < 8; k++) begin
            rand_bits(2, v);
            npages = v + 1;
            rand_bits(3, v);
            rand_bits(4, d);
            rand_bits(3, p);
            build_packet((npages - 1) * 8 + 1 + v, d[3:0], p[2:0]);
            write_packet();
            stage_readback(1'b0);
            repeat (2) @(negedge clk);
            read_packet(exp_head);
        end
        report_test("random_packets");
    endtask

    // drain every original page then run on freed ones
    task automatic page_recycling();
        logic [15:0] d;
        logic [15:0] p;
        int          k;
        while (pops_total < sram_pkg::page_count) begin
            rand_bits(4, d);
            rand_bits(3, p);
            build_packet(1, d[3:0], p[2:0]);
            write_packet();
        end
        for (k = 0; k < 3; k++) begin
            build_packet(10, 4'h5, 3'd3);   // two pages both taken from freed ones
            write_packet();
            stage_readback(1'b0);
            repeat (2) @(negedge clk);
            read_packet(exp_head);
        end
        report_test("page_recycling");
    endtask

    initial begin
        int i;
        rst_n       = 1'b0;
        wr_vld      = 1'b0;
        wr_data     = '0;
        wr_eop      = 1'b0;
        cat_en      = 1'b0;
        cat_head    = '0;
        cat_tail    = '0;
        rd_start    = 1'b0;
        rd_head     = '0;
        lfsr        = 32'hfeed_f2e4;
        err_count   = 0;
        check_count = 0;
        test_errs   = 0;
        pops_total  = 0;
        ready_seen  = 1'b0;
        for (i = 0; i < sram_pkg::page_count; i++)
            free_q.push_back(i);   // queue fills in page order
        reset_and_fill();
        one_page_packet();
        three_page_packet();
        concatenation();
        random_packets();
        page_recycling();
        $display("%0d checks, %0d errors", check_count, err_count);
        if (err_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/sram_pkg.sv
logic/page_pool_if.sv
logic/free_page_queue.sv
logic/page_ecc.sv
logic/sram.sv
logic/page_link_table.sv
logic/sram_write_ctrl.sv
logic/sram_read_ctrl.sv
logic/sram_interface.sv
tests/tb_sram_interface.sv
